//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_hw_top
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/board_pkg.sv
package board_pkg;

    //////////////////////////////////////////////////
    // Board GPIO groups
    //////////////////////////////////////////////////

    // Inputs as seen at the connector
    typedef struct packed {
        // Interlock loop states
        logic [7:0] loop_state;
        // Door and safety switches, active low
        logic [7:0] safety_n;
        // Configuration switch bank
        logic [7:0] config_sw;
    } gpio_in_t;

    // Registered outputs, 12 bits
    typedef struct packed {
        // Loop control lines
        logic [7:0] loop_ctrl;
        logic       gant_rot_en;
        logic       spare;
        // Bit 0 is LED1, bit 1 is LED2
        logic [1:0] led;
    } gpio_out_t;

    //////////////////////////////////////////////////
    // Frequency meter
    //////////////////////////////////////////////////

    // Gate length in reference ticks
    localparam int GATE_W  = 16;
    // Edge count width
    localparam int COUNT_W = 24;

    typedef enum logic [1:0] {
        FM_IDLE,
        FM_ARM,
        FM_GATE,
        FM_DONE
    } freq_state_e;

endpackage

//--- common/opb_pkg.sv
package opb_pkg;

    //////////////////////////////////////////////////
    // Register bus widths
    //////////////////////////////////////////////////

    typedef logic [31:0] opb_data_t;
    typedef logic [7:0]  opb_addr_t;

    // One bus request, 42 bits
    typedef struct packed {
        opb_addr_t addr;
        opb_data_t wdata;
        logic      re;
        logic      we;
    } opb_req_t;

    //////////////////////////////////////////////////
    // Register map, byte addresses of 32-bit words
    //////////////////////////////////////////////////

    typedef enum opb_addr_t {
        REG_VERSION    = 8'h00,
        REG_ID         = 8'h04,
        REG_DATE       = 8'h08,
        REG_SCRATCH    = 8'h0C,
        REG_GPIO_IN    = 8'h10,
        REG_GPIO_OUT   = 8'h14,
        // Bit 0 start on write; bit 0 busy, bit 1 done on read
        REG_FREQ_CTRL  = 8'h18,
        REG_FREQ_COUNT = 8'h1C
    } reg_addr_e;

endpackage

//--- design/hw_top.sv
`timescale 1ns/1ps

module hw_top
    import opb_pkg::*;
    import board_pkg::*;
#(
    parameter opb_data_t VERSION  = 32'h0001_0000,
    parameter opb_data_t ID       = 32'h0000_0050,
    parameter opb_data_t DATE     = 32'h2025_0822,
    parameter int        TICK_DIV = 10,
    parameter int        SLOW_DIV = 4
) (
    input  logic       opb_clk,
    input  logic       rst_n,
    input  opb_req_t   opb_req,
    input  gpio_in_t   gpio_in,
    input  logic       osc_in,
    output opb_data_t  opb_rdata,
    output gpio_out_t  gpio_out,
    output logic [1:0] status_led,
    output logic       ref_clk_out
);

    // Timer outputs
    logic               ref_tick;
    logic               blink;

    // Frequency meter
    logic               start;
    logic [GATE_W-1:0]  gate_len;
    logic               count_en;
    logic               count_clr;
    logic               count_latch;
    logic               busy;
    logic               done;
    logic [COUNT_W-1:0] count;

    pulse_timer #(
        .TICK_DIV (TICK_DIV),
        .SLOW_DIV (SLOW_DIV)
    ) i_pulse_timer (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .ref_tick    (ref_tick),
        .ref_clk_out (ref_clk_out),
        .blink       (blink)
    );

    freq_meter_ctrl i_freq_meter_ctrl (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .start       (start),
        .ref_tick    (ref_tick),
        .gate_len    (gate_len),
        .count_en    (count_en),
        .count_clr   (count_clr),
        .count_latch (count_latch),
        .busy        (busy),
        .done        (done)
    );

    edge_counter i_edge_counter (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .osc_in      (osc_in),
        .count_en    (count_en),
        .count_clr   (count_clr),
        .count_latch (count_latch),
        .count       (count)
    );

    reg_file #(
        .VERSION (VERSION),
        .ID      (ID),
        .DATE    (DATE)
    ) i_reg_file (
        .opb_clk    (opb_clk),
        .rst_n      (rst_n),
        .opb_req    (opb_req),
        .gpio_in    (gpio_in),
        .blink      (blink),
        .busy       (busy),
        .done       (done),
        .count      (count),
        .opb_rdata  (opb_rdata),
        .gpio_out   (gpio_out),
        .status_led (status_led),
        .start      (start),
        .gate_len   (gate_len)
    );

endmodule

//--- design/pulse_timer.sv
`timescale 1ns/1ps

module pulse_timer #(
    parameter int TICK_DIV = 10,
    parameter int SLOW_DIV = 4
) (
    input  logic opb_clk,
    input  logic rst_n,
    output logic ref_tick,
    output logic ref_clk_out,
    output logic blink
);

    localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int SLOW_W = (SLOW_DIV > 1) ? $clog2(SLOW_DIV) : 1;

    logic [TICK_W-1:0] tick_cnt;
    logic [SLOW_W-1:0] slow_cnt;

    // Prescaler wraps every TICK_DIV cycles, the tick and both
    // slow outputs are updated on the same edge
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt    <= '0;
            slow_cnt    <= '0;
            ref_tick    <= 1'b0;
            ref_clk_out <= 1'b0;
            blink       <= 1'b0;
        end else begin
            ref_tick <= 1'b0;
            if (tick_cnt == TICK_W'(TICK_DIV - 1)) begin
                tick_cnt    <= '0;
                ref_tick    <= 1'b1;
                ref_clk_out <= ~ref_clk_out;
                // Blink half period is SLOW_DIV ticks
                if (slow_cnt == SLOW_W'(SLOW_DIV - 1)) begin
                    slow_cnt <= '0;
                    blink    <= ~blink;
                end else begin
                    slow_cnt <= slow_cnt + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import opb_pkg::*;
    import board_pkg::*;
#(
    parameter opb_data_t VERSION = 32'h0,
    parameter opb_data_t ID      = 32'h0,
    parameter opb_data_t DATE    = 32'h0
) (
    input  logic               opb_clk,
    input  logic               rst_n,
    input  opb_req_t           opb_req,
    input  gpio_in_t           gpio_in,
    input  logic               blink,
    input  logic               busy,
    input  logic               done,
    input  logic [COUNT_W-1:0] count,
    output opb_data_t          opb_rdata,
    output gpio_out_t          gpio_out,
    output logic [1:0]         status_led,
    output logic               start,
    output logic [GATE_W-1:0]  gate_len
);

    reg_addr_e addr;
    opb_data_t scratch;
    opb_data_t rd_mux;
    gpio_in_t  gpio_s1;
    gpio_in_t  gpio_s2;
    logic      wakeup;

    assign addr = reg_addr_e'(opb_req.addr);

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (opb_req.we && addr == REG_SCRATCH) begin
            scratch <= opb_req.wdata;
        end
    end

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (opb_req.we && addr == REG_GPIO_OUT) begin
            gpio_out <= gpio_out_t'(opb_req.wdata[$bits(gpio_out_t)-1:0]);
        end
    end

    // Start strobe and gate length for the frequency meter
    assign start    = opb_req.we && (addr == REG_FREQ_CTRL) && opb_req.wdata[0];
    assign gate_len = opb_req.wdata[31:16];

    // Two-flop input synchronizer
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_s1 <= '0;
            gpio_s2 <= '0;
        end else begin
            gpio_s1 <= gpio_in;
            gpio_s2 <= gpio_s1;
        end
    end

    //////////////////////////////////////////////////
    // Read-back
    //////////////////////////////////////////////////

    always_comb begin
        case (addr)
            REG_VERSION:    rd_mux = VERSION;
            REG_ID:         rd_mux = ID;
            REG_DATE:       rd_mux = DATE;
            REG_SCRATCH:    rd_mux = scratch;
            REG_GPIO_IN:    rd_mux = {8'h00, gpio_s2};
            REG_GPIO_OUT:   rd_mux = {20'h0_0000, gpio_out};
            REG_FREQ_CTRL:  rd_mux = {30'h0, done, busy};
            REG_FREQ_COUNT: rd_mux = {8'h00, count};
            default:        rd_mux = '0;
        endcase
    end

    // Held until the next read strobe
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            opb_rdata <= '0;
        end else if (opb_req.re) begin
            opb_rdata <= rd_mux;
        end
    end

    //////////////////////////////////////////////////
    // Wake-up and status LEDs
    //////////////////////////////////////////////////

    // Sticky flag set by the first bus access of any kind
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            wakeup <= 1'b0;
        end else if (opb_req.re || opb_req.we) begin
            wakeup <= 1'b1;
        end
    end

    assign status_led = wakeup ? gpio_out.led : {2{blink}};

endmodule

//--- freq_meter/edge_counter.sv
`timescale 1ns/1ps

module edge_counter
    import board_pkg::*;
(
    input  logic               opb_clk,
    input  logic               rst_n,
    input  logic               osc_in,
    input  logic               count_en,
    input  logic               count_clr,
    input  logic               count_latch,
    output logic [COUNT_W-1:0] count
);

    logic               osc_s1;
    logic               osc_s2;
    logic               osc_prev;
    logic               osc_rise;
    logic [COUNT_W-1:0] run_cnt;

    //////////////////////////////////////////////////
    // Oscillator input synchronizer
    //////////////////////////////////////////////////

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            osc_s1   <= 1'b0;
            osc_s2   <= 1'b0;
            osc_prev <= 1'b0;
        end else begin
            osc_s1   <= osc_in;
            osc_s2   <= osc_s1;
            osc_prev <= osc_s2;
        end
    end

    assign osc_rise = osc_s2 && !osc_prev;

    //////////////////////////////////////////////////
    // Running count and held result
    //////////////////////////////////////////////////

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            run_cnt <= '0;
            count   <= '0;
        end else begin
            // Clear wins over counting
            if (count_clr) begin
                run_cnt <= '0;
            end else if (count_en && osc_rise) begin
                run_cnt <= run_cnt + 1'b1;
            end
            if (count_latch) begin
                count <= run_cnt;
            end
        end
    end

endmodule

//--- freq_meter/freq_meter_ctrl.sv
`timescale 1ns/1ps

module freq_meter_ctrl
    import board_pkg::*;
(
    input  logic              opb_clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              ref_tick,
    input  logic [GATE_W-1:0] gate_len,
    output logic              count_en,
    output logic              count_clr,
    output logic              count_latch,
    output logic              busy,
    output logic              done
);

    freq_state_e       state;
    freq_state_e       state_nxt;
    logic [GATE_W-1:0] gate_q;
    logic [GATE_W-1:0] tick_cnt;
    logic              accept;
    logic              last_tick;

    // A start is only taken when no measurement is running
    assign accept    = start && (state == FM_IDLE || state == FM_DONE);
    assign last_tick = ref_tick && (tick_cnt == gate_q - 1'b1);

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            FM_IDLE, FM_DONE: begin
                if (start) begin
                    state_nxt = FM_ARM;
                end
            end
            // Wait for a tick boundary so the gate is whole ticks
            FM_ARM: begin
                if (ref_tick) begin
                    state_nxt = FM_GATE;
                end
            end
            FM_GATE: begin
                if (last_tick) begin
                    state_nxt = FM_DONE;
                end
            end
            default: state_nxt = FM_IDLE;
        endcase
    end

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FM_IDLE;
            gate_q   <= '0;
            tick_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                gate_q <= gate_len;
            end
            // Gate tick counter
            if (state == FM_ARM) begin
                tick_cnt <= '0;
            end else if (state == FM_GATE && ref_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign count_clr   = accept;
    assign count_en    = (state == FM_GATE);
    assign count_latch = (state == FM_GATE) && last_tick;
    assign busy        = (state == FM_ARM) || (state == FM_GATE);
    assign done        = (state == FM_DONE);

endmodule

//--- tb.f
common/opb_pkg.sv
common/board_pkg.sv
design/pulse_timer.sv
freq_meter/freq_meter_ctrl.sv
freq_meter/edge_counter.sv
design/reg_file.sv
design/hw_top.sv
testbench/tb_hw_top.sv

//--- testbench/tb_hw_top.sv
`timescale 1ns/1ps

module tb_hw_top
    import opb_pkg::*;
    import board_pkg::*;
();

    localparam opb_data_t VERSION  = 32'h0001_0000;
    localparam opb_data_t ID       = 32'h0000_0050;
    localparam opb_data_t DATE     = 32'h2025_0822;
    localparam int        TICK_DIV = 10;
    localparam int        SLOW_DIV = 4;

    // Rough length of each test in cycles
    localparam int RESET_CYCLES = 8;
    localparam int BLINK_CYCLES = 200;
    localparam int BUS_CYCLES   = 300;
    localparam int FREQ_CYCLES  = 1000;
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + BLINK_CYCLES + BUS_CYCLES + FREQ_CYCLES);

    logic       opb_clk;
    logic       rst_n;
    opb_req_t   opb_req;
    gpio_in_t   gpio_in;
    logic       osc_in;
    opb_data_t  opb_rdata;
    gpio_out_t  gpio_out;
    logic [1:0] status_led;
    logic       ref_clk_out;

    // Model of the written registers and driven inputs
    opb_data_t model_scratch;
    gpio_out_t model_gpio_out;
    gpio_in_t  model_gpio_in;

    opb_data_t exp_q[$];
    string     name_q[$];
    logic      rd_seen;
    int        osc_period;
    int        osc_phase;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;

    always #2 opb_clk = ~opb_clk;

    hw_top #(
        .VERSION  (VERSION),
        .ID       (ID),
        .DATE     (DATE),
        .TICK_DIV (TICK_DIV),
        .SLOW_DIV (SLOW_DIV)
    ) i_dut (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .opb_req     (opb_req),
        .gpio_in     (gpio_in),
        .osc_in      (osc_in),
        .opb_rdata   (opb_rdata),
        .gpio_out    (gpio_out),
        .status_led  (status_led),
        .ref_clk_out (ref_clk_out)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Frequency meter registers are not modelled here
    function automatic opb_data_t exp_read(input opb_addr_t addr);
        case (addr)
            REG_VERSION:  return VERSION;
            REG_ID:       return ID;
            REG_DATE:     return DATE;
            REG_SCRATCH:  return model_scratch;
            REG_GPIO_IN:  return {8'h00, model_gpio_in};
            REG_GPIO_OUT: return {20'h0_0000, model_gpio_out};
            default:      return '0;
        endcase
    endfunction

    // Edges of a period-P oscillator inside a gate of G ticks
    function automatic int exp_count(input int gate, input int period);
        return gate * TICK_DIV / period;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_data(input string name, input opb_data_t exp, input opb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_gpio(input string name, input gpio_out_t exp, input gpio_out_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_led(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Gate and oscillator are not phase locked, so allow one edge either way
    task automatic check_count(input string name, input logic [COUNT_W-1:0] exp,
                               input logic [COUNT_W-1:0] act);
        int diff;
        checks++;
        diff = int'(act) - int'(exp);
        if ($isunknown(act) || diff > 1 || diff < -1) begin
            errors++;
            $display("Fail %s: expected %0d within one, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_int(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Bus access tasks start and end on a falling edge
    //////////////////////////////////////////////////

    task automatic bus_write(input opb_addr_t addr, input opb_data_t data);
        opb_req.addr  = addr;
        opb_req.wdata = data;
        opb_req.we    = 1'b1;
        @(negedge opb_clk);
        opb_req.we = 1'b0;
        if (addr == REG_SCRATCH) begin
            model_scratch = data;
        end
        if (addr == REG_GPIO_OUT) begin
            model_gpio_out = data[11:0];
        end
    endtask

    task automatic bus_read(input opb_addr_t addr, output opb_data_t data);
        opb_req.addr = addr;
        opb_req.re   = 1'b1;
        @(negedge opb_clk);
        opb_req.re = 1'b0;
        data = opb_rdata;
    endtask

    // Expected word goes to the compare process
    task automatic read_expect(input string name, input opb_addr_t addr);
        opb_data_t unused;
        exp_q.push_back(exp_read(addr));
        name_q.push_back(name);
        bus_read(addr, unused);
    endtask

    always @(posedge opb_clk) begin
        rd_seen <= opb_req.re;
    end

    always @(negedge opb_clk) begin
        if (rd_seen === 1'b1 && exp_q.size() > 0) begin
            check_data(name_q.pop_front(), exp_q.pop_front(), opb_rdata);
        end
    end

    // Oscillator under test with its period in cycles
    // A zero period holds it low
    initial begin
        osc_in    = 1'b0;
        osc_phase = 0;
        forever begin
            @(negedge opb_clk);
            if (osc_period > 0) begin
                osc_phase = (osc_phase + 1) % osc_period;
                osc_in    = (osc_phase < osc_period / 2);
            end else begin
                osc_in = 1'b0;
            end
        end
    end

    always @(posedge opb_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic watch_blink(input int cycles_n);
        logic led_q;
        logic ref_q;
        int   led_t;
        int   ref_t;
        int   led_n;
        led_q = status_led[0];
        ref_q = ref_clk_out;
        led_t = -1;
        ref_t = -1;
        led_n = 0;
        for (int k = 0; k < cycles_n; k++) begin
            @(negedge opb_clk);
            if (status_led[0] !== status_led[1]) begin
                errors++;
                $display("Status LEDs differ before wake-up at cycle %0d", k);
            end
            if (status_led[0] !== led_q) begin
                if (led_t >= 0) begin
                    check_int("blink half period", TICK_DIV * SLOW_DIV, k - led_t);
                end
                led_t = k;
                led_q = status_led[0];
                led_n++;
            end
            if (ref_clk_out !== ref_q) begin
                if (ref_t >= 0) begin
                    check_int("ref_clk_out half period", TICK_DIV, k - ref_t);
                end
                ref_t = k;
                ref_q = ref_clk_out;
            end
        end
        if (led_n < 3) begin
            errors++;
            $display("Status LEDs did not blink before wake-up");
        end
    endtask

    task automatic measure_freq(input int period, input int gate, input bit restart);
        opb_data_t rd;
        int        polls;
        osc_period = period;
        repeat (2 * period) @(negedge opb_clk);
        bus_write(REG_FREQ_CTRL, {gate[15:0], 16'h0001});
        polls = 0;
        rd    = '0;
        while (rd[1] !== 1'b1) begin
            bus_read(REG_FREQ_CTRL, rd);
            polls++;
            if (polls == 1 && rd[0] !== 1'b1) begin
                errors++;
                $display("Frequency meter not busy after start, period %0d", period);
            end
            // Short gate start while busy
            if (restart && polls == 1) begin
                bus_write(REG_FREQ_CTRL, 32'h0001_0001);
            end
        end
        bus_read(REG_FREQ_COUNT, rd);
        check_count($sformatf("count P=%0d G=%0d", period, gate),
                    COUNT_W'(exp_count(gate, period)), rd[COUNT_W-1:0]);
    endtask

    initial begin
        opb_data_t w;
        opb_clk        = 1'b0;
        rst_n          = 1'b0;
        opb_req        = '0;
        gpio_in        = '0;
        osc_period     = 0;
        model_scratch  = '0;
        model_gpio_out = '0;
        model_gpio_in  = '0;
        void'($urandom(32'he31b_032b));
        repeat (RESET_CYCLES) @(negedge opb_clk);
        rst_n = 1'b1;

        watch_blink(BLINK_CYCLES);

        // ID words, unmapped and read-only addresses
        read_expect("version", REG_VERSION);
        read_expect("id", REG_ID);
        read_expect("date", REG_DATE);
        read_expect("unmapped", 8'h20);
        bus_write(REG_VERSION, $urandom());
        bus_write(REG_ID, $urandom());
        bus_write(REG_DATE, $urandom());
        bus_write(REG_GPIO_IN, $urandom());
        read_expect("version after write", REG_VERSION);
        read_expect("id after write", REG_ID);
        read_expect("date after write", REG_DATE);
        read_expect("gpio_in after write", REG_GPIO_IN);

        for (int i = 0; i < 10; i++) begin
            w = $urandom();
            bus_write(REG_SCRATCH, w);
            read_expect("scratch", REG_SCRATCH);
        end

        for (int i = 0; i < 5; i++) begin
            w             = $urandom();
            gpio_in       = w[23:0];
            model_gpio_in = w[23:0];
            repeat (4) @(negedge opb_clk);
            read_expect("gpio_in", REG_GPIO_IN);
        end

        w = $urandom();
        bus_write(REG_GPIO_OUT, w);
        check_gpio("gpio_out", model_gpio_out, gpio_out);
        read_expect("gpio_out read", REG_GPIO_OUT);
        check_led("status_led after wake-up", model_gpio_out.led, status_led);

        measure_freq(6, 5, 1'b0);
        measure_freq(4, 8, 1'b1);
        @(negedge opb_clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
